// File: list.f
+incdir+include
source/cmd_engine_pkg.sv
source/ahb_slave_port.sv
source/addr_decoder.sv
source/cmd_buffer.sv
source/cmd_exec_fsm.sv
source/target_regs.sv
source/cmd_engine_top.sv
tests/cmd_engine_tb.sv

// File: tests/cmd_engine_tb.sv
// Testbench for the command engine behind its AHB-Lite slave port
// Loads command lists over AHB, starts runs and compares the target bank
// with a reference model kept here; all reads go through the slave port
// Checks are assertions; the first failing one stops the run

`include "cmd_engine_config.svh"

module cmd_engine_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         max_cycles = 4000;   // About 900 cycles of traffic plus margin
    localparam int         n_cmds     = 8;
    localparam logic [1:0] ht_idle    = 2'b00;
    localparam logic [1:0] ht_nonseq  = 2'b10;

    logic        clk;
    logic        rst_n;
    logic        hsel;
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;

    logic [15:0] lfsr;
    int          cycles = 0;
    logic [31:0] ref_regs [`TGT_DEPTH];     // Expected target bank
    logic [31:0] cmd_data [n_cmds];
    logic [2:0]  cmd_tgt  [n_cmds];         // Few targets so commands overlap
    logic [1:0]  cmd_op   [n_cmds];

    cmd_engine_top cmd_engine_top_i (
        .clk(clk), .rst_n(rst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
        .hwrite(hwrite), .hwdata(hwdata), .hrdata(hrdata), .hready(hready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
            fail_stop($sformatf("Timeout, the run did not finish within %0d cycles", max_cycles));
    end

    // A read may hold hready low for one cycle only
    a_single_wait: assert property (@(posedge clk) disable iff (!rst_n) !hready |=> hready)
        else fail_stop("hready stayed low for more than one cycle");

    // --------------------
    // Checking helpers
    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else fail_stop($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    // Status layout: count 5:0, seq_error 8, busy 9
    function automatic logic [31:0] status_word(input logic busy, input logic err, input int count);
        return (32'(busy) << 9) | (32'(err) << 8) | 32'(count);
    endfunction

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];                 // One step per bit taken
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // --------------------
    // AHB driver
    task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        hsel   <= 1'b1;
        htrans <= ht_nonseq;
        hwrite <= 1'b1;
        haddr  <= addr;
        @(posedge clk);                     // Address phase taken
        hsel   <= 1'b0;
        htrans <= ht_idle;
        hwdata <= data;
        @(negedge clk);
        check_eq("hready", {31'h0, hready}, 32'h1);     // Writes have no wait state
        @(posedge clk);
    endtask

    task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
        int waits;
        @(posedge clk);
        hsel   <= 1'b1;
        htrans <= ht_nonseq;
        hwrite <= 1'b0;
        haddr  <= addr;
        @(posedge clk);
        hsel   <= 1'b0;
        htrans <= ht_idle;
        waits = 0;
        @(negedge clk);
        while (!hready) begin
            waits++;
            @(negedge clk);
        end
        assert (waits == 1)
        else fail_stop($sformatf("Read of 0x%08h took %0d wait states instead of one",
                                 addr, waits));
        data = hrdata;                      // Valid where hready returns high
    endtask

    task automatic read_check(input string name, input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        ahb_read(addr, got);
        check_eq(name, got, exp);
    endtask

    task automatic load_cmd(input int slot, input logic [31:0] data, input logic [5:0] tgt,
                            input logic [1:0] op);
        ahb_write(`WIN_CMD + 8 * slot, data);               // Data word
        ahb_write(`WIN_CMD + 8 * slot + 4, {24'h0, tgt, op});   // Address/op word commits
    endtask

    task automatic check_targets();
        for (int i = 0; i < `TGT_DEPTH; i++)
            read_check($sformatf("hrdata tgt[%0d]", i), `WIN_TGT + 4 * i, ref_regs[i]);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        do
            ahb_read(`WIN_CTRL, st);        // Poll status until busy falls
        while (st[9]);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < `TGT_DEPTH; i++)
            ref_regs[i] = '0;
    endtask

    // --------------------
    // Test sequence
    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        hsel   = 1'b0;
        haddr  = '0;
        htrans = ht_idle;
        hwrite = 1'b0;
        hwdata = '0;
        lfsr   = 16'd49426;
        apply_reset();

        // Idle state after reset
        @(negedge clk);
        check_eq("hready", {31'h0, hready}, 32'h1);
        read_check("hrdata status", `WIN_CTRL, status_word(1'b0, 1'b0, 0));
        check_targets();

        // Random list, last command forced to WRITE
        for (int k = 0; k < n_cmds; k++) begin
            cmd_data[k] = rand_bits(32);
            cmd_tgt[k]  = 3'(rand_bits(3));
            cmd_op[k]   = (k == n_cmds - 1) ? 2'd0 : 2'(rand_bits(1));
            load_cmd(k, cmd_data[k], {3'b000, cmd_tgt[k]}, cmd_op[k]);
        end
        for (int k = 0; k < n_cmds; k++) begin
            read_check($sformatf("hrdata cmd[%0d] data", k), `WIN_CMD + 8 * k, cmd_data[k]);
            read_check($sformatf("hrdata cmd[%0d] addr/op", k), `WIN_CMD + 8 * k + 4,
                       {24'h0, 3'b000, cmd_tgt[k], cmd_op[k]});
        end
        read_check("hrdata status", `WIN_CTRL, status_word(1'b0, 1'b0, n_cmds));

        // Run the list, busy visible and target window blanked meanwhile
        ahb_write(`WIN_CTRL, 32'h1);
        read_check("hrdata status", `WIN_CTRL, status_word(1'b1, 1'b0, n_cmds));
        read_check("hrdata tgt while busy", `WIN_TGT + 4 * cmd_tgt[0], 32'h0);
        wait_idle();
        for (int k = 0; k < n_cmds; k++) begin
            if (cmd_op[k] == 2'd1)
                ref_regs[cmd_tgt[k]] = ref_regs[cmd_tgt[k]] | cmd_data[k];     // RWM
            else
                ref_regs[cmd_tgt[k]] = cmd_data[k];                            // WRITE
        end
        read_check("hrdata status", `WIN_CTRL, status_word(1'b0, 1'b0, 0));
        check_targets();

        // List ending in RWM is refused
        for (int k = 0; k < 2; k++)
            load_cmd(k, rand_bits(32), 6'(rand_bits(3)), 2'(k));
        ahb_write(`WIN_CTRL, 32'h1);
        read_check("hrdata status", `WIN_CTRL, status_word(1'b0, 1'b1, 2));
        check_targets();

        // Illegal opcode on a fresh engine
        apply_reset();
        load_cmd(0, rand_bits(32), 6'(rand_bits(3)), 2'd0);
        read_check("hrdata status", `WIN_CTRL, status_word(1'b0, 1'b0, 1));
        load_cmd(1, rand_bits(32), 6'(rand_bits(3)), 2'd2);
        read_check("hrdata status", `WIN_CTRL, status_word(1'b0, 1'b1, 0));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: source/cmd_engine_top.sv
// Command engine behind an AHB-Lite slave port
// Connects the slave port, the address decoder, the command buffer,
// the executor and the target register bank

`include "cmd_engine_config.svh"

module cmd_engine_top
    import cmd_engine_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hsel,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready
);

    bus_req_t           req;
    bus_req_t           buf_req;
    bus_req_t           tgt_req;
    bus_rsp_t           rsp;
    bus_rsp_t           buf_rsp;
    bus_rsp_t           tgt_rsp;
    win_e               win;
    logic               start;
    logic               start_ok;
    logic [`CMD_AW:0]   count;
    logic               seq_error;
    logic               busy;
    logic               run_done;
    logic               cmd_rd_en;
    logic [`CMD_AW-1:0] cmd_addr;
    logic               cmd_rd_valid;
    cmd_t               cmd_out;
    logic               tgt_en;
    logic               tgt_we;
    logic [`TGT_AW-1:0] tgt_idx;
    logic [31:0]        tgt_wdata;
    logic [31:0]        tgt_rdata;

    ahb_slave_port ahb_slave_port_i (
        .clk(clk), .rst_n(rst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
        .hwrite(hwrite), .hwdata(hwdata), .hrdata(hrdata), .hready(hready),
        .req(req), .win(win), .rsp(rsp)
    );

    addr_decoder addr_decoder_i (
        .clk(clk), .rst_n(rst_n), .req(req), .win(win), .count(count),
        .seq_error(seq_error), .busy(busy), .buf_req(buf_req), .tgt_req(tgt_req),
        .start(start), .buf_rsp(buf_rsp), .tgt_rsp(tgt_rsp), .rsp(rsp)
    );

    cmd_buffer cmd_buffer_i (
        .clk(clk), .rst_n(rst_n), .buf_req(buf_req), .buf_rsp(buf_rsp),
        .cmd_rd_en(cmd_rd_en), .cmd_addr(cmd_addr), .cmd_rd_valid(cmd_rd_valid),
        .cmd_out(cmd_out), .count(count), .seq_error(seq_error), .start(start),
        .busy(busy), .run_done(run_done), .start_ok(start_ok)
    );

    cmd_exec_fsm cmd_exec_fsm_i (
        .clk(clk), .rst_n(rst_n), .start_ok(start_ok), .count(count),
        .cmd_rd_en(cmd_rd_en), .cmd_addr(cmd_addr), .cmd_rd_valid(cmd_rd_valid),
        .cmd_out(cmd_out), .busy(busy), .run_done(run_done), .tgt_en(tgt_en),
        .tgt_we(tgt_we), .tgt_idx(tgt_idx), .tgt_wdata(tgt_wdata), .tgt_rdata(tgt_rdata)
    );

    target_regs target_regs_i (
        .clk(clk), .rst_n(rst_n), .en(tgt_en), .we(tgt_we), .idx(tgt_idx),
        .wdata(tgt_wdata), .rdata(tgt_rdata), .bus_req(tgt_req), .bus_rsp(tgt_rsp),
        .busy(busy)
    );

endmodule

// File: source/target_regs.sv
// Target register bank written by the executor
// One synchronous port, owned by the executor while busy and by AHB otherwise
// Reads answer one cycle after the request, AHB reads during a run return zero

`include "cmd_engine_config.svh"

module target_regs
    import cmd_engine_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               we,
    input  logic [`TGT_AW-1:0] idx,
    input  logic [31:0]        wdata,
    output logic [31:0]        rdata,
    input  bus_req_t           bus_req,
    output bus_rsp_t           bus_rsp,
    input  logic               busy
);

    logic [31:0]        regs [`TGT_DEPTH];
    logic               p_en;       // Shared port after arbitration
    logic               p_we;
    logic [`TGT_AW-1:0] p_idx;
    logic [31:0]        p_wdata;
    logic [31:0]        rd_q;
    logic               bus_rd;
    logic               bus_own;    // AHB owned the port for that read

    assign p_en    = busy ? en    : bus_req.valid;
    assign p_we    = busy ? we    : bus_req.write;
    assign p_idx   = busy ? idx   : bus_req.addr[`TGT_AW-1:0];
    assign p_wdata = busy ? wdata : bus_req.wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TGT_DEPTH; i++) begin
                regs[i] <= '0;
            end
            bus_rd  <= 1'b0;
            bus_own <= 1'b0;
        end else begin
            if (p_en && p_we)
                regs[p_idx] <= p_wdata;
            bus_rd  <= bus_req.valid && !bus_req.write;
            bus_own <= !busy;
        end
    end

    always_ff @(posedge clk) begin
        if (p_en && !p_we)
            rd_q <= regs[p_idx];
    end

    assign rdata            = rd_q;
    assign bus_rsp.rd_valid = bus_rd;
    assign bus_rsp.rdata    = bus_own ? rd_q : 32'h0;   // Zero while a run holds the port

endmodule

// File: source/cmd_exec_fsm.sv
// Executor of the command engine
// Fetches commands 0 to count-1 and applies them to the target bank:
// a WRITE takes FETCH and READ (2 cycles), an RWM adds a WRITE cycle that
// stores the old value OR the data (3 cycles)
// busy is high from the first fetch until the run_done cycle in NEXT

`include "cmd_engine_config.svh"

module cmd_exec_fsm
    import cmd_engine_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_ok,
    input  logic [`CMD_AW:0]   count,
    output logic               cmd_rd_en,
    output logic [`CMD_AW-1:0] cmd_addr,
    input  logic               cmd_rd_valid,
    input  cmd_t               cmd_out,
    output logic               busy,
    output logic               run_done,
    output logic               tgt_en,
    output logic               tgt_we,
    output logic [`TGT_AW-1:0] tgt_idx,
    output logic [31:0]        tgt_wdata,
    input  logic [31:0]        tgt_rdata
);

    typedef enum logic [2:0] {IDLE, FETCH, READ, WRITE, NEXT} state_e;

    state_e             state;
    state_e             state_nxt;
    logic [`CMD_AW-1:0] idx;        // Command being executed
    logic               last_cmd;
    logic [`TGT_AW-1:0] rwm_idx;    // RWM target held for the write cycle
    logic [31:0]        rwm_data;

    assign last_cmd = (({1'b0, idx} + 1'b1) == count);
    assign cmd_addr = idx;
    assign busy     = (state != IDLE);
    assign run_done = (state == NEXT);

    always_comb begin
        state_nxt = state;
        cmd_rd_en = 1'b0;
        tgt_en    = 1'b0;
        tgt_we    = 1'b0;
        tgt_idx   = cmd_out.tgt_addr[`TGT_AW-1:0];
        tgt_wdata = cmd_out.data;
        case (state)
            IDLE: if (start_ok) state_nxt = FETCH;
            FETCH: begin
                cmd_rd_en = 1'b1;
                state_nxt = READ;
            end
            READ: if (cmd_rd_valid) begin
                tgt_en = 1'b1;                          // RWM reads, WRITE writes
                if (cmd_out.op == OP_RWM) begin
                    state_nxt = WRITE;
                end else begin
                    tgt_we    = 1'b1;
                    state_nxt = last_cmd ? NEXT : FETCH;
                end
            end
            WRITE: begin
                tgt_en    = 1'b1;
                tgt_we    = 1'b1;
                tgt_idx   = rwm_idx;
                tgt_wdata = tgt_rdata | rwm_data;       // Old value OR data
                state_nxt = last_cmd ? NEXT : FETCH;
            end
            NEXT:    state_nxt = IDLE;                  // Run done, buffer clears count
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            state <= state_nxt;
            if (state == IDLE)
                idx <= '0;
            else if (state_nxt == FETCH)
                idx <= idx + 1'b1;                      // Move to next command
        end
    end

    always_ff @(posedge clk) begin
        if (state == READ) begin
            rwm_idx  <= cmd_out.tgt_addr[`TGT_AW-1:0];
            rwm_data <= cmd_out.data;
        end
    end

endmodule

// File: source/cmd_buffer.sv
// Command list storage of the command engine
// Software writes the data word of a command, then its address/op word;
// the second write commits the whole command at the next free slot
// A run may only start on a list that ends in a WRITE, and an illegal
// opcode empties the list, both errors set the sticky seq_error flag
// Also serves the executor's fetch port and the debug readback

`include "cmd_engine_config.svh"

module cmd_buffer
    import cmd_engine_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  bus_req_t           buf_req,
    output bus_rsp_t           buf_rsp,
    input  logic               cmd_rd_en,
    input  logic [`CMD_AW-1:0] cmd_addr,
    output logic               cmd_rd_valid,
    output cmd_t               cmd_out,
    output logic [`CMD_AW:0]   count,
    output logic               seq_error,
    input  logic               start,
    input  logic               busy,
    input  logic               run_done,
    output logic               start_ok
);

    cmd_t               mem [`CMD_DEPTH];
    logic [31:0]        stage_data;     // Data word waiting for its addr/op word
    logic               stage_full;
    logic               last_write;     // Last stored command is a WRITE
    logic               locked;         // Run starting or running
    logic               wr_even;
    logic               wr_odd;
    logic               bad_op;
    logic               commit;
    cmd_op_e            new_op;
    logic [`CMD_AW-1:0] dbg_idx;
    logic               dbg_rd;
    logic               dbg_valid;
    logic [31:0]        dbg_data;

    assign locked  = busy || start_ok;
    assign wr_even = buf_req.valid && buf_req.write && !locked && !buf_req.addr[0];
    assign wr_odd  = buf_req.valid && buf_req.write && !locked && buf_req.addr[0];
    assign new_op  = cmd_op_e'(buf_req.wdata[1:0]);
    assign bad_op  = wr_odd && ((new_op == OP_RSV2) || (new_op == OP_RSV3));
    assign commit  = wr_odd && !bad_op && stage_full && (count < `CMD_DEPTH);  // Full list drops
    assign dbg_rd  = buf_req.valid && !buf_req.write;
    assign dbg_idx = buf_req.addr[`CMD_AW:1];       // Two words per command

    // --------------------
    // Storage and list control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CMD_DEPTH; i++) begin
                mem[i] <= '0;
            end
            count      <= '0;
            stage_full <= 1'b0;
            last_write <= 1'b0;
            seq_error  <= 1'b0;
            start_ok   <= 1'b0;
        end else begin
            start_ok <= 1'b0;
            if (run_done) begin
                count      <= '0;               // List consumed
                last_write <= 1'b0;
            end else if (bad_op) begin
                count      <= '0;               // Illegal opcode empties the list
                last_write <= 1'b0;
                seq_error  <= 1'b1;
            end else if (commit) begin
                mem[count[`CMD_AW-1:0]] <= '{tgt_addr: buf_req.wdata[31:2],
                                             data:     stage_data,
                                             op:       new_op};
                count      <= count + 1'b1;
                last_write <= (new_op == OP_WRITE);
            end

            if (wr_even)
                stage_full <= 1'b1;
            else if (wr_odd)
                stage_full <= 1'b0;

            // Start qualification
            if (start && !locked) begin
                if ((count != '0) && last_write)
                    start_ok <= 1'b1;
                else
                    seq_error <= 1'b1;          // Empty list or trailing RWM
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_even)
            stage_data <= buf_req.wdata;
    end

    // --------------------
    // Executor fetch and debug readback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_rd_valid <= 1'b0;
            dbg_valid    <= 1'b0;
        end else begin
            cmd_rd_valid <= cmd_rd_en;
            dbg_valid    <= dbg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_rd_en)
            cmd_out <= mem[cmd_addr];
        if (dbg_rd)
            dbg_data <= buf_req.addr[0] ? {mem[dbg_idx].tgt_addr, mem[dbg_idx].op}
                                        : mem[dbg_idx].data;
    end

    assign buf_rsp.rd_valid = dbg_valid;
    assign buf_rsp.rdata    = dbg_data;

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= `CMD_DEPTH)
        else $error("command count beyond buffer depth");

endmodule

// File: source/addr_decoder.sv
// Routes decoded bus requests to the command buffer, the control register
// and the target bank, and merges their read answers into one response
// Control window offset 0 starts a run on a write with bit 0 set
// and returns the status word on a read, one cycle after the request

`include "cmd_engine_config.svh"

module addr_decoder
    import cmd_engine_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  bus_req_t           req,
    input  win_e               win,
    input  logic [`CMD_AW:0]   count,
    input  logic               seq_error,
    input  logic               busy,
    output bus_req_t           buf_req,
    output bus_req_t           tgt_req,
    output logic               start,
    input  bus_rsp_t           buf_rsp,
    input  bus_rsp_t           tgt_rsp,
    output bus_rsp_t           rsp
);

    logic        stat_rd;       // Control read this cycle
    logic        stat_valid;
    logic [31:0] stat_word;

    always_comb begin
        buf_req       = req;
        buf_req.valid = req.valid && (win == WIN_CMD_E);
        tgt_req       = req;
        tgt_req.valid = req.valid && (win == WIN_TGT_E);
    end

    assign start   = req.valid && req.write && (win == WIN_CTRL_E)
                     && (req.addr == 12'h0) && req.wdata[0];
    assign stat_rd = req.valid && !req.write && (win == WIN_CTRL_E);

    // --------------------
    // Status word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            stat_valid <= 1'b0;
        else
            stat_valid <= stat_rd;
    end

    always_ff @(posedge clk) begin
        if (stat_rd)
            stat_word <= {22'h0, busy, seq_error, 2'b00, count};   // busy 9, error 8, count 5:0
    end

    // Each window's data only counts while it is valid
    assign rsp.rd_valid = buf_rsp.rd_valid | tgt_rsp.rd_valid | stat_valid;
    assign rsp.rdata    = (buf_rsp.rd_valid ? buf_rsp.rdata : 32'h0)
                        | (tgt_rsp.rd_valid ? tgt_rsp.rdata : 32'h0)
                        | (stat_valid       ? stat_word     : 32'h0);

    a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({buf_rsp.rd_valid, tgt_rsp.rd_valid, stat_valid}))
        else $error("more than one window answered in the same cycle");

endmodule

// File: source/ahb_slave_port.sv
// AHB-Lite slave front end of the command engine
// Samples the address phase, issues one request per selected NONSEQ transfer
// in its data phase and adds a single wait state to every read
// Writes complete with hready high and land one cycle after the data phase

`include "cmd_engine_config.svh"

module ahb_slave_port
    import cmd_engine_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hsel,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output bus_req_t    req,
    output win_e        win,
    input  bus_rsp_t    rsp
);

    localparam logic [1:0]  htrans_nonseq = 2'b10;
    localparam logic [31:0] cmd_base      = `WIN_CMD;
    localparam logic [31:0] ctrl_base     = `WIN_CTRL;
    localparam logic [31:0] tgt_base      = `WIN_TGT;

    logic        accept;    // Address phase taken this cycle
    win_e        win_d;     // Window of the address phase
    logic        dp_valid;  // Data phase in progress, first cycle
    logic        dp_write;
    logic [11:0] dp_addr;
    logic        rd_wait;   // Second data-phase cycle of a read

    assign accept = hsel && (htrans == htrans_nonseq) && hready;

    always_comb begin
        win_d = WIN_NONE_E;                                     // Unmapped by default
        if (haddr[31:12] == cmd_base[31:12])  win_d = WIN_CMD_E;
        if (haddr[31:12] == ctrl_base[31:12]) win_d = WIN_CTRL_E;
        if (haddr[31:12] == tgt_base[31:12])  win_d = WIN_TGT_E;
    end

    // --------------------
    // Address phase capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
            rd_wait  <= 1'b0;
            dp_write <= 1'b0;
            win      <= WIN_NONE_E;
        end else begin
            dp_valid <= accept;                     // Drops while hready is low
            rd_wait  <= dp_valid && !dp_write;      // Read answer due next cycle
            if (accept) begin
                dp_write <= hwrite;
                win      <= win_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            dp_addr <= {2'b00, haddr[11:2]};        // Word offset in a 4 KB window
    end

    // --------------------
    // Data phase
    always_comb begin
        req.valid = dp_valid;
        req.write = dp_write;
        req.addr  = dp_addr;
        req.wdata = hwdata;                         // Master drives it in the data phase
    end

    assign hready = !(dp_valid && !dp_write);       // One wait state per read
    assign hrdata = rd_wait ? rsp.rdata : 32'h0;

    // A window may only answer the read that is waiting for it
    a_rsp_pending: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.rd_valid |-> rd_wait)
        else $error("read response without a pending read");

endmodule

// File: source/cmd_engine_pkg.sv
// Types shared by the command engine blocks
// Compiled first, then pulled into each module header by a wildcard import

package cmd_engine_pkg;

    // Opcode in bits 1:0 of the address/op word
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,    // Store data
        OP_RWM   = 2'd1,    // Store old value OR data
        OP_RSV2  = 2'd2,    // Illegal
        OP_RSV3  = 2'd3     // Illegal
    } cmd_op_e;

    // One stored command, 64 bits
    typedef struct packed {
        logic [29:0] tgt_addr;  // Target word address
        logic [31:0] data;      // Payload
        cmd_op_e     op;        // Opcode
    } cmd_t;

    // Decoded bus transfer, 46 bits
    typedef struct packed {
        logic        valid;     // One cycle in the data phase
        logic        write;     // 1 = write
        logic [11:0] addr;      // Word offset inside the window
        logic [31:0] wdata;     // Write data
    } bus_req_t;

    // Read answer from a window, 33 bits
    typedef struct packed {
        logic        rd_valid;
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        WIN_NONE_E,
        WIN_CMD_E,
        WIN_CTRL_E,
        WIN_TGT_E
    } win_e;

endpackage

// File: include/cmd_engine_config.svh
// Sizes and address map of the command engine
// Included by every RTL file that needs a depth, a width or a window base
// Window bases are byte addresses on the AHB side, each window spans 4 KB

`ifndef CMD_ENGINE_CONFIG_SVH
`define CMD_ENGINE_CONFIG_SVH

// Command buffer
`define CMD_DEPTH 32            // Commands held per list
`define CMD_AW    5             // Command index bits

// Target register bank
`define TGT_DEPTH 64            // Number of target registers
`define TGT_AW    6             // Target index bits

// AHB address windows
`define WIN_CMD   32'h0000_0000 // Command words, 2k data and 2k+1 addr/op
`define WIN_CTRL  32'h0000_1000 // Start on write, status on read
`define WIN_TGT   32'h0000_2000 // Target registers, readable when idle

`endif
